// File: Bender.yml
package:
  name: vga_sys

dependencies: {}

sources:
  - vga_pkg.sv
  - vga.sv
  - wb_regs.sv
  - sprite_mixer.sv
  - vga_top.sv
  - target: simulation
    files:
      - tb_vga_top.sv

// File: sprite_mixer.sv
// Two-stage pixel mixer: picks sprite colour, background colour or black for each pixel step
`timescale 1ns/10ps
`default_nettype none

module sprite_mixer
    import vga_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         pix_en,
    input  vga_pos_t    pos,
    input  sprite_cfg_t cfg,
    output rgb_t        rgb,
    output logic        blank_n
);

    sprite_cfg_t shadow;        // Config frozen for the current frame
    sprite_cfg_t cur_cfg;
    logic        frame_start;
    logic        hit_x;
    logic        hit_y;

    // Stage 1 results
    logic        s1_inside;
    logic        s1_display;

    assign frame_start = (pos.hpos == '0) && (pos.vpos == '0);

    // At the first pixel of a frame the new config is used right away,
    // otherwise pixel 0,0 would still see the previous frame
    assign cur_cfg = frame_start ? cfg : shadow;

    // Range checks by difference, so sprite_x near the top of the
    // counter range cannot wrap
    assign hit_x = (pos.hpos >= cur_cfg.sprite_x)
                && ((pos.hpos - cur_cfg.sprite_x) < hpos_t'(SPRITE_SIZE));
    assign hit_y = (pos.vpos >= cur_cfg.sprite_y)
                && ((pos.vpos - cur_cfg.sprite_y) < vpos_t'(SPRITE_SIZE));

    // Shadow copy taken once per frame, so a bus write never tears
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shadow <= '0;
        else if (pix_en && frame_start)
            shadow <= cfg;
    end

    // Stage 1: sprite hit test
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            s1_inside  <= 1'b0;
            s1_display <= 1'b0;
        end
        else if (pix_en)
        begin
            s1_inside  <= cur_cfg.sprite_on && hit_x && hit_y;
            s1_display <= pos.display_on;
        end
    end

    // Stage 2: colour select.
    // Shadow is already up to date here, even for pixel 0,0
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rgb     <= '0;
            blank_n <= 1'b0;
        end
        else if (pix_en)
        begin
            blank_n <= s1_display;

            if (!s1_display)
                rgb <= '0;                      // Blanking, DAC must see black
            else if (s1_inside)
                rgb <= shadow.sprite_color;
            else
                rgb <= shadow.bg_color;
        end
    end

    // Black during blanking
    black_when_blank: assert property (
        @(posedge clk) disable iff (reset)
        !blank_n |-> (rgb == '0)
    )
    else
        $error("sprite_mixer: colour %h during blanking", rgb);

endmodule

`default_nettype wire

// File: tb_vga_top.sv
// Self-checking testbench for vga_top: drives the Wishbone port and checks timing and frame pixels
`timescale 1ns/10ps
`default_nettype none

module tb_vga_top
    import vga_pkg::*;
();

    localparam int LINE_PIX  = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int LINE_CLK  = 2 * LINE_PIX;                 // Two clocks per pixel
    localparam int FRAME_CLK = LINE_CLK * (V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP);
    localparam int SEL_HSYNC = 0;
    localparam int SEL_VSYNC = 1;
    localparam int SEL_BLANK = 2;
    localparam int BUS = 0;                            // Error kinds
    localparam int TIMING = 1;
    localparam int PIXEL = 2;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    logic        hsync;
    logic        vsync;
    logic        blank_n;
    rgb_t        rgb;

    sprite_cfg_t model_cfg;     // What the bus has been told
    sprite_cfg_t frame_cfg;     // Taken when the checked frame is armed
    rgb_t        want_rgb;
    int          errors [3];
    int          printed;
    int          pixels_checked;
    int          frame_state;   // 0 idle, 1 wait vsync, 2 wait blank_n, 3 counting
    int          pix_count;
    logic        phase;
    logic        prev_vsync;
    logic        prev_blank;
    logic        reset_done;

    always #10 clk = ~clk;

    vga_top UUT (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank_n  (blank_n),
        .rgb      (rgb)
    );

    // Colour a pixel should have under the mixer rule
    function automatic rgb_t expected_rgb(input int x, input int y, input sprite_cfg_t c);
        int sx;
        int sy;
        sx = int'(c.sprite_x);
        sy = int'(c.sprite_y);
        if (c.sprite_on && x >= sx && x < sx + SPRITE_SIZE && y >= sy && y < sy + SPRITE_SIZE)
            return c.sprite_color;
        return c.bg_color;
    endfunction

    // Readable width of each register
    function automatic wb_data_t field_mask(input wb_addr_t adr);
        case (adr)
            REG_BG, REG_SPR_COLOR: return 16'h0fff;
            REG_SPR_X, REG_SPR_Y:  return 16'h03ff;
            REG_CTRL:              return 16'h0001;
            default:               return 16'h0000;
        endcase
    endfunction

    function automatic logic video_bit(input int which);
        case (which)
            SEL_HSYNC: return hsync;
            SEL_VSYNC: return vsync;
            default:   return blank_n;
        endcase
    endfunction

    task automatic report(input int kind, input string sig, input int exp_v, input int got_v);
        errors[kind]++;
        if (printed < 100)
            $display("error at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, got_v);
        else if (printed == 100)
            $display("Too many errors, the rest are only counted");
        printed++;
    endtask

    task automatic print_counts();
        $display("Errors: bus %0d, timing %0d, pixel %0d (%0d pixels compared)",
                 errors[BUS], errors[TIMING], errors[PIXEL], pixels_checked);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        print_counts();
        $display("=== FAIL ===");
        $finish;
    endtask

    // All outputs held low around reset
    task automatic check_outputs_low();
        if (hsync !== 1'b0) report(TIMING, "hsync", 0, hsync);
        if (vsync !== 1'b0) report(TIMING, "vsync", 0, vsync);
        if (blank_n !== 1'b0) report(TIMING, "blank_n", 0, blank_n);
        if (rgb !== 12'h000) report(TIMING, "rgb", 0, rgb);
        if (wb_ack !== 1'b0) report(BUS, "wb_ack", 0, wb_ack);
    endtask

    task automatic wait_level(input int which, input logic level, input int limit,
                              input string what);
        int n;
        n = 0;
        while (video_bit(which) !== level)
        begin
            @(negedge clk);
            n++;
            if (n > limit)
                abort_run(what);
        end
    endtask

    // Clocks for which a signal keeps its present level
    task automatic run_length(input int which, input logic level, output int clocks);
        clocks = 0;
        while (video_bit(which) === level)
        begin
            @(negedge clk);
            clocks++;
            if (clocks > FRAME_CLK)
                abort_run("a video signal to toggle");
        end
    endtask

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdat);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 20)
                abort_run("wb_ack");
        end
        while (wb_ack !== 1'b1);
        rdat = wb_dat_r;
        if (n != 1) report(BUS, "wb_ack latency", 1, n);
        // Request stays up through the ack cycle
        @(negedge clk);
        if (wb_ack !== 1'b0) report(BUS, "wb_ack second cycle", 0, wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        case (adr)
            REG_BG:        model_cfg.bg_color     = dat[11:0];
            REG_SPR_COLOR: model_cfg.sprite_color = dat[11:0];
            REG_SPR_X:     model_cfg.sprite_x     = dat[9:0];
            REG_SPR_Y:     model_cfg.sprite_y     = dat[9:0];
            REG_CTRL:      model_cfg.sprite_on    = dat[0];
            default:       ;
        endcase
    endtask

    task automatic read_check(input wb_addr_t adr, input wb_data_t want);
        wb_data_t got;
        bus_cycle(1'b0, adr, 16'h0000, got);
        if (got !== want) report(BUS, $sformatf("wb_dat_r at %0d", adr), want, got);
    endtask

    // Main process waits here while the checker walks one frame
    task automatic check_frame(input string what);
        int n;
        frame_state = 1;
        n = 0;
        while (frame_state != 0)
        begin
            @(negedge clk);
            n++;
            if (n > 3 * FRAME_CLK)
                abort_run(what);
        end
    endtask

    task automatic check_line_timing();
        int low_clk;
        int high_clk;
        wait_level(SEL_HSYNC, 1'b1, LINE_CLK, "hsync high");
        wait_level(SEL_HSYNC, 1'b0, LINE_CLK, "hsync falling");
        run_length(SEL_HSYNC, 1'b0, low_clk);
        run_length(SEL_HSYNC, 1'b1, high_clk);
        if (low_clk != 2 * H_SYNC) report(TIMING, "hsync low clocks", 2 * H_SYNC, low_clk);
        if (low_clk + high_clk != LINE_CLK)
            report(TIMING, "hsync period clocks", LINE_CLK, low_clk + high_clk);
        wait_level(SEL_VSYNC, 1'b1, FRAME_CLK, "vsync high");
        wait_level(SEL_VSYNC, 1'b0, FRAME_CLK, "vsync falling");
        run_length(SEL_VSYNC, 1'b0, low_clk);
        if (low_clk != V_SYNC * LINE_CLK)
            report(TIMING, "vsync low clocks", V_SYNC * LINE_CLK, low_clk);
        wait_level(SEL_BLANK, 1'b1, FRAME_CLK, "blank_n rising");
        run_length(SEL_BLANK, 1'b1, high_clk);
        if (high_clk != 2 * H_DISPLAY)
            report(TIMING, "blank_n high clocks", 2 * H_DISPLAY, high_clk);
    endtask

    // Frame checker, samples where outputs are stable
    always @(negedge clk)
    begin
        if (reset_done)
        begin
            if (!blank_n && rgb !== 12'h000) report(PIXEL, "rgb while blanked", 0, rgb);
            if (frame_state == 1 && prev_vsync && !vsync)
            begin
                frame_cfg   = model_cfg;
                frame_state = 2;
            end
            else if (frame_state == 2 && !prev_blank && blank_n)
            begin
                pix_count   = 0;
                phase       = 1'b0;
                frame_state = 3;
            end
            if (frame_state == 3)
            begin
                phase = ~phase;    // One pixel per two clocks
                if (phase && blank_n)
                begin
                    want_rgb = expected_rgb(pix_count % H_DISPLAY, pix_count / H_DISPLAY,
                                            frame_cfg);
                    pixels_checked++;
                    if (rgb !== want_rgb)
                        report(PIXEL, $sformatf("rgb at %0d,%0d", pix_count % H_DISPLAY,
                               pix_count / H_DISPLAY), want_rgb, rgb);
                    pix_count++;
                    if (pix_count == H_DISPLAY * V_DISPLAY)
                        frame_state = 0;
                end
            end
            prev_vsync = vsync;
            prev_blank = blank_n;
        end
    end

    initial
    begin
        wb_data_t wr_val [8];
        int       seed_val;
        clk = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        model_cfg = '0;
        errors = '{0, 0, 0};
        printed = 0;
        pixels_checked = 0;
        frame_state = 0;
        prev_vsync = 1'b0;
        prev_blank = 1'b0;
        reset_done = 1'b0;
        seed_val = $urandom(20288);

        // Outputs quiet during reset and just after release
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            if (i == 3) reset = 1'b0;
            check_outputs_low();
        end
        @(negedge clk);
        check_outputs_low();
        reset_done = 1'b1;

        for (int a = 0; a < 8; a++)
        begin
            wr_val[a] = wb_data_t'($urandom());
            write_reg(wb_addr_t'(a), wr_val[a]);
        end
        for (int a = 0; a < 8; a++)
            read_check(wb_addr_t'(a), wr_val[a] & field_mask(wb_addr_t'(a)));

        check_line_timing();

        write_reg(REG_CTRL, 16'h0000);
        write_reg(REG_BG, wb_data_t'($urandom()));
        check_frame("background frame");

        write_reg(REG_SPR_COLOR, wb_data_t'($urandom()));
        write_reg(REG_BG, wb_data_t'($urandom()));
        write_reg(REG_SPR_X, wb_data_t'($urandom() % (H_DISPLAY - SPRITE_SIZE + 1)));
        write_reg(REG_SPR_Y, wb_data_t'($urandom() % (V_DISPLAY - SPRITE_SIZE + 1)));
        write_reg(REG_CTRL, 16'h0001);
        check_frame("sprite frame");

        write_reg(REG_SPR_X, 16'd630);    // Cut off by the right edge
        check_frame("right edge sprite frame");

        print_counts();
        if (errors[BUS] + errors[TIMING] + errors[PIXEL] == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: vga.sv
// Timing generator: derives the pixel enable from clk and produces position and sync for 640x480
`timescale 1ns/10ps
`default_nettype none

module vga
    import vga_pkg::*;
(
    input  wire      clk,
    input  wire      reset,
    output logic     hsync,
    output logic     vsync,
    output vga_pos_t pos,
    output logic     pix_en
);

    hpos_t      d_hpos;
    vpos_t      d_vpos;
    logic [1:0] div_cnt;    // Clock divider for the pixel rate

    // Next counter values, wrapping at the end of line and frame
    always_comb
    begin
        d_hpos = pos.hpos + 1'd1;
        d_vpos = pos.vpos;

        if (pos.hpos == H_MAX)
        begin
            d_hpos = '0;

            if (pos.vpos == V_MAX)
                d_vpos = '0;
            else
                d_vpos = pos.vpos + 1'd1;
        end
    end

    // One pulse every CLK_MHZ / VGA_CLOCK clocks
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            pix_en  <= 1'b0;
        end
        else if (div_cnt == 2'(CLK_MHZ / VGA_CLOCK - 1))
        begin
            div_cnt <= '0;
            pix_en  <= 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 2'd1;
            pix_en  <= 1'b0;
        end
    end

    // Everything leaves the generator from a register.
    // Sync levels are worked out from the next position so they
    // change together with pos.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hsync          <= 1'b0;
            vsync          <= 1'b0;
            pos.display_on <= 1'b0;
            pos.hpos       <= '0;
            pos.vpos       <= '0;
        end
        else if (pix_en)
        begin
            hsync <= ~(d_hpos >= H_SYNC_START && d_hpos <= H_SYNC_END);    // Active low
            vsync <= ~(d_vpos >= V_SYNC_START && d_vpos <= V_SYNC_END);

            pos.display_on <= (d_hpos < H_DISPLAY) && (d_vpos < V_DISPLAY);
            pos.hpos       <= d_hpos;
            pos.vpos       <= d_vpos;
        end
    end

    // Counters stay inside the frame at all times
    pos_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (pos.hpos <= H_MAX) && (pos.vpos <= V_MAX)
    )
    else
        $error("vga: position %0d,%0d outside frame", pos.hpos, pos.vpos);

endmodule

`default_nettype wire

// File: vga_pkg.sv
// Shared package for the VGA subsystem: video timing, register map and bus/pixel types
`default_nettype none

package vga_pkg;

    // Horizontal timing in pixels
    localparam int H_DISPLAY = 640;
    localparam int H_FRONT   = 16;    // Front porch
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;    // Back porch

    // Vertical timing in lines
    localparam int V_DISPLAY = 480;
    localparam int V_BOTTOM  = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOP     = 33;

    localparam int CLK_MHZ   = 50;    // Board clock
    localparam int VGA_CLOCK = 25;    // Pixel rate

    // Depth of the colour mixer, in pixel steps
    localparam int MIXER_STAGES = 2;

    // Hsync is pushed back by the mixer depth so it lines up with rgb
    localparam int H_SYNC_START = H_DISPLAY + H_FRONT + MIXER_STAGES;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC - 1;
    localparam int H_MAX        = H_DISPLAY + H_FRONT + H_SYNC + H_BACK - 1;
    localparam int V_SYNC_START = V_DISPLAY + V_BOTTOM;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC - 1;
    localparam int V_MAX        = V_SYNC_END + V_TOP;

    localparam int SPRITE_SIZE = 16;  // Side length of the square

    typedef logic [9:0]  hpos_t;
    typedef logic [9:0]  vpos_t;
    typedef logic [11:0] rgb_t;       // {r, g, b}, 4 bits each
    typedef logic [2:0]  wb_addr_t;   // Word address
    typedef logic [15:0] wb_data_t;

    // Register map
    localparam wb_addr_t REG_BG        = 3'd0;
    localparam wb_addr_t REG_SPR_COLOR = 3'd1;
    localparam wb_addr_t REG_SPR_X     = 3'd2;
    localparam wb_addr_t REG_SPR_Y     = 3'd3;
    localparam wb_addr_t REG_CTRL      = 3'd4;  // Bit 0 enables the sprite

    typedef struct packed {
        rgb_t  bg_color;
        rgb_t  sprite_color;
        hpos_t sprite_x;
        vpos_t sprite_y;
        logic  sprite_on;
    } sprite_cfg_t;

    typedef struct packed {
        hpos_t hpos;
        vpos_t vpos;
        logic  display_on;
    } vga_pos_t;

endpackage

`default_nettype wire

// File: vga_sys.f
vga_pkg.sv
vga.sv
wb_regs.sv
sprite_mixer.sv
vga_top.sv
tb_vga_top.sv

// File: vga_top.sv
// Top level of the VGA subsystem: Wishbone register slave, timing generator and sprite mixer
`timescale 1ns/10ps
`default_nettype none

module vga_top
    import vga_pkg::*;
(
    input  wire      clk,
    input  wire      reset,

    // Wishbone classic slave
    input  wire      wb_cyc,
    input  wire      wb_stb,
    input  wire      wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,

    // Video out
    output logic     hsync,
    output logic     vsync,
    output logic     blank_n,
    output rgb_t     rgb
);

    sprite_cfg_t cfg;       // Live register values
    vga_pos_t    pos;
    logic        pix_en;

    wb_regs u_wb_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg)
    );

    // Hsync already carries the mixer delay
    vga u_vga (
        .clk    (clk),
        .reset  (reset),
        .hsync  (hsync),
        .vsync  (vsync),
        .pos    (pos),
        .pix_en (pix_en)
    );

    sprite_mixer u_sprite_mixer (
        .clk     (clk),
        .reset   (reset),
        .pix_en  (pix_en),
        .pos     (pos),
        .cfg     (cfg),
        .rgb     (rgb),
        .blank_n (blank_n)
    );

endmodule

`default_nettype wire

// File: wb_regs.sv
// Wishbone classic slave with the background colour, sprite colour, position and control registers
`timescale 1ns/10ps
`default_nettype none

module wb_regs
    import vga_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wb_addr_t    wb_adr,
    input  wb_data_t    wb_dat_w,
    output wb_data_t    wb_dat_r,
    output logic        wb_ack,
    output sprite_cfg_t cfg
);

    wb_data_t rd_data;
    logic     req;

    // New request only while no ack is pending
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Read mux, fields zero-extended to the bus width
    always_comb
    begin
        case (wb_adr)
            REG_BG:        rd_data = wb_data_t'(cfg.bg_color);
            REG_SPR_COLOR: rd_data = wb_data_t'(cfg.sprite_color);
            REG_SPR_X:     rd_data = wb_data_t'(cfg.sprite_x);
            REG_SPR_Y:     rd_data = wb_data_t'(cfg.sprite_y);
            REG_CTRL:      rd_data = wb_data_t'(cfg.sprite_on);
            default:       rd_data = '0;    // Unused addresses read 0
        endcase
    end

    // Fixed one-cycle acknowledge
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= req;
    end

    // Read data is captured alongside the ack
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wb_dat_r <= '0;
        else if (req)
            wb_dat_r <= rd_data;
    end

    // Register writes, upper data bits dropped
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cfg <= '0;    // Sprite off, black background
        end
        else if (req && wb_we)
        begin
            case (wb_adr)
                REG_BG:        cfg.bg_color     <= wb_dat_w[11:0];
                REG_SPR_COLOR: cfg.sprite_color <= wb_dat_w[11:0];
                REG_SPR_X:     cfg.sprite_x     <= wb_dat_w[9:0];
                REG_SPR_Y:     cfg.sprite_y     <= wb_dat_w[9:0];
                REG_CTRL:      cfg.sprite_on    <= wb_dat_w[0];
                default:
                begin
                    // Ignored
                end
            endcase
        end
    end

    // The master keeps strobe up until it sees the ack
    ack_needs_stb: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |-> wb_stb
    )
    else
        $error("wb_regs: ack without strobe");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack
    )
    else
        $error("wb_regs: ack held for two cycles");

endmodule

`default_nettype wire
